/* src.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/instr_decoder.sv
hdl/sequencer.sv
hdl/alu.sv
hdl/datapath.sv
hdl/cpu_core.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_cpu_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cpu_core
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/cpu_core_vectors.txt */
// Program image bytes at their @ addresses; @10000 holds program bytes, expected writes, halt
// address; @10008 holds the expected write trace, one {addr, data} word per write
@0200
A9 5A 8D 00 03
AE 00 04 AC 01 04 8E 01 03 8C 02 03
AD 02 04 8D 03 03
A9 F0 69 20 6D 03 04 8D 04 03
E9 07 ED 04 04 8D 05 03
29 0F 09 A0 4D 05 04 8D 06 03
A9 7F 69 81 2A 8D 07 03
A9 81 0A 6A 8D 08 03 4A 8D 09 03
A2 FF E8 8E 0A 03 A0 00 88 8C 0B 03 CA 8E 0C 03
4C 5C 02 8D 0D 03 02 8C 0E 03 4C 60 02
@0400
80 01 C3 05 10 FF
@FFFC
00 02
@10000
000063 00000E 000260
@10008
03005A 030180 030201 0303C3 030416 0305FE 030651
030701 030881 030940 030A00 030BFF 030CFF 030EFF

/* testbench/tb_cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_core;

	localparam int MEM_DEPTH   = 1 << `ADDR_W;
	localparam int HDR_BASE    = MEM_DEPTH;
	localparam int TRACE_BASE  = MEM_DEPTH + 8;
	localparam int VEC_DEPTH   = MEM_DEPTH + 64;
	localparam int WORD_W      = `ADDR_W + `DATA_W;
	localparam int DRIVE_DELAY = 1;

	logic               sys_clk;
	logic               rst_n;
	logic [`ADDR_W-1:0] bus_addr;
	logic [`DATA_W-1:0] bus_rdata;
	logic [`DATA_W-1:0] bus_wdata;
	logic               bus_we;

	logic [WORD_W-1:0]  vec_mem [0:VEC_DEPTH-1];
	logic [`DATA_W-1:0] mem [0:MEM_DEPTH-1];

	int                 prog_bytes;
	int                 exp_writes;
	int                 cycle_limit;
	int                 cycle_count;
	int                 write_index;
	int                 error_count;
	logic [`ADDR_W-1:0] start_addr;
	logic [`ADDR_W-1:0] halt_addr;
	logic [WORD_W-1:0]  exp_write;
	logic               checks_done;
	logic               wr_pending = 1'b0;
	logic [`ADDR_W-1:0] wr_addr;
	logic [`DATA_W-1:0] wr_data;

	tb_clock_gen #(
		.PERIOD_NS    (100),
		.RESET_CYCLES (4)
	) u_clock_gen (
		.sys_clk_o (sys_clk),
		.rst_n_o   (rst_n)
	);

	cpu_core DUT (
		.sys_clk_i   (sys_clk),
		.rst_n_i     (rst_n),
		.bus_rdata_i (bus_rdata),
		.bus_addr_o  (bus_addr),
		.bus_wdata_o (bus_wdata),
		.bus_we_o    (bus_we)
	);

	tb_checker u_checker (
		.sys_clk_i     (sys_clk),
		.rst_n_i       (rst_n),
		.bus_addr_i    (bus_addr),
		.bus_wdata_i   (bus_wdata),
		.bus_we_i      (bus_we),
		.start_addr_i  (start_addr),
		.halt_addr_i   (halt_addr),
		.exp_writes_i  (exp_writes),
		.exp_write_i   (exp_write),
		.write_index_o (write_index),
		.error_count_o (error_count),
		.done_o        (checks_done)
	);

	assign bus_rdata = mem[bus_addr];
	assign exp_write = vec_mem[TRACE_BASE + write_index];

	// Write request taken mid-cycle, memory updates just after the edge
	always @(negedge sys_clk) begin
		wr_pending = bus_we;
		wr_addr    = bus_addr;
		wr_data    = bus_wdata;
	end

	always @(posedge sys_clk) begin
		if (wr_pending)
			#(DRIVE_DELAY) mem[wr_addr] = wr_data;
	end

	task automatic load_vectors();
		for (int i = 0; i < VEC_DEPTH; i++) begin
			if (i < MEM_DEPTH)
				vec_mem[i] = WORD_W'(i[15:8] ^ i[7:0] ^ 8'ha5);
			else
				vec_mem[i] = '0;
		end
		$readmemh("testbench/cpu_core_vectors.txt", vec_mem);
		for (int i = 0; i < MEM_DEPTH; i++)
			mem[i] = vec_mem[i][`DATA_W-1:0];
		prog_bytes  = int'(vec_mem[HDR_BASE]);
		exp_writes  = int'(vec_mem[HDR_BASE + 1]);
		halt_addr   = vec_mem[HDR_BASE + 2][`ADDR_W-1:0];
		start_addr  = {vec_mem[`RESET_VECTOR + 1][`DATA_W-1:0],
			vec_mem[`RESET_VECTOR][`DATA_W-1:0]};
		cycle_limit = 4 * prog_bytes + 50;
	endtask

	initial begin
		load_vectors();
		cycle_count = 0;
		while (!checks_done && cycle_count < cycle_limit) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		if (!checks_done)
			$display("Timeout: no halt loop reached within %0d cycles", cycle_limit);
		$display("Errors: %0d, writes seen: %0d of %0d expected", error_count, write_index,
			exp_writes);
		if (checks_done && error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_checker (
	input  logic                         sys_clk_i,
	input  logic                         rst_n_i,
	input  logic [`ADDR_W-1:0]           bus_addr_i,
	input  logic [`DATA_W-1:0]           bus_wdata_i,
	input  logic                         bus_we_i,
	input  logic [`ADDR_W-1:0]           start_addr_i,
	input  logic [`ADDR_W-1:0]           halt_addr_i,
	input  int                           exp_writes_i,
	input  logic [`ADDR_W+`DATA_W-1:0]   exp_write_i,
	output int                           write_index_o,
	output int                           error_count_o,
	output logic                         done_o
);

	int                 cycle_index = 0;
	int                 write_index = 0;
	int                 error_count = 0;
	logic               done = 1'b0;
	logic [`ADDR_W-1:0] prev_addr = '0;

	assign write_index_o = write_index;
	assign error_count_o = error_count;
	assign done_o        = done;

	task automatic compare_value(input string name, input logic [`ADDR_W-1:0] exp_val,
		input logic [`ADDR_W-1:0] got_val);
		if (got_val !== exp_val) begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_val,
				got_val);
			error_count++;
		end
	endtask

	task automatic match_write();
		if (write_index >= exp_writes_i) begin
			$display("Unexpected extra write at %0t ns: address %h data %h, only %0d expected",
				$time, bus_addr_i, bus_wdata_i, exp_writes_i);
			error_count++;
		end else begin
			compare_value("bus_addr_o", exp_write_i[`ADDR_W+`DATA_W-1:`DATA_W], bus_addr_i);
			compare_value("bus_wdata_o", `ADDR_W'(exp_write_i[`DATA_W-1:0]),
				`ADDR_W'(bus_wdata_i));
		end
		write_index++;
	endtask

	task automatic close_trace();
		if (write_index < exp_writes_i) begin
			$display("Missing writes: the core reached its halt loop after %0d of %0d writes",
				write_index, exp_writes_i);
			error_count++;
		end
		done = 1'b1;
	endtask

	// Bus is stable in the middle of the cycle
	always @(negedge sys_clk_i) begin
		if (rst_n_i !== 1'b1) begin
			if (bus_we_i) begin
				$display("Bus write during reset at %0t ns", $time);
				error_count++;
			end
		end else if (!done) begin
			// Vector low, vector high, then the first opcode
			case (cycle_index)
				0: compare_value("bus_addr_o", `RESET_VECTOR, bus_addr_i);
				1: compare_value("bus_addr_o", `RESET_VECTOR + `ADDR_W'(1), bus_addr_i);
				2: compare_value("bus_addr_o", start_addr_i, bus_addr_i);
				default: ;
			endcase
			cycle_index++;
			if (bus_we_i)
				match_write();
			// JMP to itself shows its high operand byte and then its own opcode again
			if (bus_addr_i == halt_addr_i && prev_addr == halt_addr_i + `ADDR_W'(2))
				close_trace();
			prev_addr = bus_addr_i;
		end
	end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 4,
	parameter int DRIVE_DELAY  = 10
) (
	output logic sys_clk_o,
	output logic rst_n_o
);

	initial begin
		sys_clk_o = 1'b0;
		forever #(PERIOD_NS / 2) sys_clk_o = ~sys_clk_o;
	end

	// Release lands just after a rising edge
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge sys_clk_o);
		#(DRIVE_DELAY) rst_n_o = 1'b1;
	end

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core (
	input  logic                sys_clk_i,
	input  logic                rst_n_i,
	input  logic [`DATA_W-1:0]  bus_rdata_i,
	output logic [`ADDR_W-1:0]  bus_addr_o,
	output logic [`DATA_W-1:0]  bus_wdata_o,
	output logic                bus_we_o
);

	import cpu_pkg::*;

	opcode_e            opcode;
	addr_mode_e         mode;
	logic               pc_addr_oe, pc_inc, pc_load, ir_we;
	a_src_e             a_src;
	b_src_e             b_src;
	dst_e               dst;
	alu_func_e          alu_func;
	logic [`DATA_W-1:0] p_mask;
	logic [`DATA_W-1:0] ir, alu_a, alu_b, alu_result;
	status_u            status, alu_status;

	instr_decoder u_decoder (
		.ir_i     (ir),
		.opcode_o (opcode),
		.mode_o   (mode)
	);

	sequencer u_sequencer (
		.sys_clk_i    (sys_clk_i),
		.rst_n_i      (rst_n_i),
		.opcode_i     (opcode),
		.mode_i       (mode),
		.pc_addr_oe_o (pc_addr_oe),
		.pc_inc_o     (pc_inc),
		.pc_load_o    (pc_load),
		.ir_we_o      (ir_we),
		.bus_we_o     (bus_we_o),
		.a_src_o      (a_src),
		.b_src_o      (b_src),
		.dst_o        (dst),
		.alu_func_o   (alu_func),
		.p_mask_o     (p_mask)
	);

	alu u_alu (
		.func_i   (alu_func),
		.a_i      (alu_a),
		.b_i      (alu_b),
		.status_i (status),
		.result_o (alu_result),
		.status_o (alu_status)
	);

	datapath u_datapath (
		.sys_clk_i    (sys_clk_i),
		.rst_n_i      (rst_n_i),
		.bus_rdata_i  (bus_rdata_i),
		.pc_addr_oe_i (pc_addr_oe),
		.pc_inc_i     (pc_inc),
		.pc_load_i    (pc_load),
		.ir_we_i      (ir_we),
		.a_src_i      (a_src),
		.b_src_i      (b_src),
		.dst_i        (dst),
		.alu_func_i   (alu_func),
		.p_mask_i     (p_mask),
		.alu_result_i (alu_result),
		.alu_status_i (alu_status),
		.alu_a_o      (alu_a),
		.alu_b_o      (alu_b),
		.ir_o         (ir),
		.status_o     (status),
		.bus_addr_o   (bus_addr_o),
		.bus_wdata_o  (bus_wdata_o)
	);

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module datapath (
	input  logic                 sys_clk_i,
	input  logic                 rst_n_i,
	input  logic [`DATA_W-1:0]   bus_rdata_i,
	input  logic                 pc_addr_oe_i,
	input  logic                 pc_inc_i,
	input  logic                 pc_load_i,
	input  logic                 ir_we_i,
	input  cpu_pkg::a_src_e      a_src_i,
	input  cpu_pkg::b_src_e      b_src_i,
	input  cpu_pkg::dst_e        dst_i,
	input  cpu_pkg::alu_func_e   alu_func_i,
	input  logic [`DATA_W-1:0]   p_mask_i,
	input  logic [`DATA_W-1:0]   alu_result_i,
	input  cpu_pkg::status_u     alu_status_i,
	output logic [`DATA_W-1:0]   alu_a_o,
	output logic [`DATA_W-1:0]   alu_b_o,
	output logic [`DATA_W-1:0]   ir_o,
	output cpu_pkg::status_u     status_o,
	output logic [`ADDR_W-1:0]   bus_addr_o,
	output logic [`DATA_W-1:0]   bus_wdata_o
);

	import cpu_pkg::*;

	logic [`DATA_W-1:0] acc_q, x_q, y_q, ir_q, adl_q, adh_q;
	logic [`ADDR_W-1:0] pc_q;
	status_u            status_q;
	logic               we_acc, we_x, we_y, we_adl, we_adh;

	assign we_acc = (dst_i == DST_ACC);
	assign we_x   = (dst_i == DST_X);
	assign we_y   = (dst_i == DST_Y);
	assign we_adl = (dst_i == DST_ADL);
	assign we_adh = (dst_i == DST_ADH);

	always_comb begin
		case (a_src_i)
			A_SRC_ACC: alu_a_o = acc_q;
			A_SRC_X:   alu_a_o = x_q;
			A_SRC_Y:   alu_a_o = y_q;
			default:   alu_a_o = bus_rdata_i;
		endcase
	end

	assign alu_b_o = (b_src_i == B_SRC_ONE) ? `DATA_W'(1) : bus_rdata_i;

	// Counts step by exactly one whatever the carry flag holds
	always_comb begin
		status_o = status_q;
		if (b_src_i == B_SRC_ONE)
			status_o.flags.c = (alu_func_i == ALU_SUB);
	end

	always_ff @(posedge sys_clk_i) begin
		if (we_acc) acc_q <= alu_result_i;
		if (we_x)   x_q   <= alu_result_i;
		if (we_y)   y_q   <= alu_result_i;
		if (we_adl) adl_q <= alu_result_i;
		if (we_adh) adh_q <= alu_result_i;
		if (ir_we_i) ir_q <= bus_rdata_i;
	end

	// High byte comes straight from the bus in the same cycle it is latched
	always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= `RESET_VECTOR;
			status_q.raw <= '0;
		end else begin
			if (pc_load_i)
				pc_q <= {alu_result_i, adl_q};
			else if (pc_inc_i)
				pc_q <= pc_q + 1'b1;
			status_q.raw <= (status_q.raw & ~p_mask_i) | (alu_status_i.raw & p_mask_i);
		end
	end

	assign ir_o        = ir_q;
	assign bus_addr_o  = pc_addr_oe_i ? pc_q : {adh_q, adl_q};
	assign bus_wdata_o = alu_result_i;

	a_one_dst: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		$onehot0({we_acc, we_x, we_y, we_adl, we_adh, ir_we_i}))
		else $error("more than one register written in one cycle");

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
	input  cpu_pkg::alu_func_e  func_i,
	input  logic [`DATA_W-1:0]  a_i,
	input  logic [`DATA_W-1:0]  b_i,
	input  cpu_pkg::status_u    status_i,
	output logic [`DATA_W-1:0]  result_o,
	output cpu_pkg::status_u    status_o
);

	import cpu_pkg::*;

	localparam int MSB = `DATA_W - 1;

	logic [`DATA_W:0] sum_add;
	logic [`DATA_W:0] sum_sub;

	// Subtract as A + ~B + C, carry set means no borrow
	assign sum_add = {1'b0, a_i} + {1'b0, b_i} + {{`DATA_W{1'b0}}, status_i.flags.c};
	assign sum_sub = {1'b0, a_i} + {1'b0, ~b_i} + {{`DATA_W{1'b0}}, status_i.flags.c};

	always_comb begin
		status_o = status_i;
		result_o = b_i;
		case (func_i)
			ALU_TXA: result_o = a_i;
			ALU_TXB: result_o = b_i;
			ALU_ADD: begin
				result_o = sum_add[MSB:0];
				status_o.flags.c = sum_add[`DATA_W];
				status_o.flags.v = (a_i[MSB] == b_i[MSB]) && (sum_add[MSB] != a_i[MSB]);
			end
			ALU_SUB: begin
				result_o = sum_sub[MSB:0];
				status_o.flags.c = sum_sub[`DATA_W];
				status_o.flags.v = (a_i[MSB] != b_i[MSB]) && (sum_sub[MSB] != a_i[MSB]);
			end
			ALU_AND: result_o = a_i & b_i;
			ALU_ORA: result_o = a_i | b_i;
			ALU_EOR: result_o = a_i ^ b_i;
			ALU_ASL: begin
				result_o = {a_i[MSB-1:0], 1'b0};
				status_o.flags.c = a_i[MSB];
			end
			ALU_LSR: begin
				result_o = {1'b0, a_i[MSB:1]};
				status_o.flags.c = a_i[0];
			end
			// Rotates go through the carry
			ALU_ROL: begin
				result_o = {a_i[MSB-1:0], status_i.flags.c};
				status_o.flags.c = a_i[MSB];
			end
			ALU_ROR: begin
				result_o = {status_i.flags.c, a_i[MSB:1]};
				status_o.flags.c = a_i[0];
			end
			default: result_o = b_i;
		endcase
		status_o.flags.n = result_o[MSB];
		status_o.flags.z = (result_o == '0);
	end

endmodule

/* hdl/sequencer.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module sequencer (
	input  logic                 sys_clk_i,
	input  logic                 rst_n_i,
	input  cpu_pkg::opcode_e     opcode_i,
	input  cpu_pkg::addr_mode_e  mode_i,
	output logic                 pc_addr_oe_o,
	output logic                 pc_inc_o,
	output logic                 pc_load_o,
	output logic                 ir_we_o,
	output logic                 bus_we_o,
	output cpu_pkg::a_src_e      a_src_o,
	output cpu_pkg::b_src_e      b_src_o,
	output cpu_pkg::dst_e        dst_o,
	output cpu_pkg::alu_func_e   alu_func_o,
	output logic [`DATA_W-1:0]   p_mask_o
);

	import cpu_pkg::*;

	typedef enum logic [2:0] {
		FETCH, DECODE, READ_H, ABSOLUTE, JUMP_L, JUMP_H
	} state_e;

	state_e state;
	state_e state_next;
	logic   execute;

	always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state <= JUMP_L;
		else
			state <= state_next;
	end

	always_comb begin
		pc_addr_oe_o = 1'b0;
		pc_inc_o     = 1'b0;
		pc_load_o    = 1'b0;
		ir_we_o      = 1'b0;
		bus_we_o     = 1'b0;
		a_src_o      = A_SRC_BUS;
		b_src_o      = B_SRC_BUS;
		dst_o        = DST_NONE;
		alu_func_o   = ALU_TXB;
		p_mask_o     = '0;
		execute      = 1'b0;
		state_next   = state;

		case (state)
			FETCH: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				ir_we_o = 1'b1;
				state_next = DECODE;
			end
			DECODE: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				state_next = FETCH;
				case (mode_i)
					// Next opcode is already on the bus so PC holds
					MODE_IMP: begin
						pc_inc_o = 1'b0;
						execute = 1'b1;
					end
					MODE_IMM: execute = 1'b1;
					MODE_ABS: begin
						dst_o = DST_ADL;
						state_next = READ_H;
					end
					default: ;
				endcase
			end
			READ_H: begin
				pc_addr_oe_o = 1'b1;
				dst_o = DST_ADH;
				if (opcode_i == OP_JMP) begin
					pc_load_o = 1'b1;
					state_next = FETCH;
				end else begin
					pc_inc_o = 1'b1;
					state_next = ABSOLUTE;
				end
			end
			// Address latch drives the bus here
			ABSOLUTE: begin
				execute = 1'b1;
				state_next = FETCH;
			end
			JUMP_L: begin
				pc_addr_oe_o = 1'b1;
				pc_inc_o = 1'b1;
				dst_o = DST_ADL;
				state_next = JUMP_H;
			end
			JUMP_H: begin
				pc_addr_oe_o = 1'b1;
				pc_load_o = 1'b1;
				dst_o = DST_ADH;
				state_next = FETCH;
			end
			default: state_next = JUMP_L;
		endcase

		if (execute) begin
			// Operands and destination
			case (opcode_i)
				OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
				OP_ASL, OP_LSR, OP_ROL, OP_ROR: begin
					a_src_o = A_SRC_ACC;
					dst_o = DST_ACC;
				end
				OP_LDA: dst_o = DST_ACC;
				OP_LDX: dst_o = DST_X;
				OP_LDY: dst_o = DST_Y;
				OP_STA: a_src_o = A_SRC_ACC;
				OP_STX: a_src_o = A_SRC_X;
				OP_STY: a_src_o = A_SRC_Y;
				OP_INX, OP_DEX: begin
					a_src_o = A_SRC_X;
					b_src_o = B_SRC_ONE;
					dst_o = DST_X;
				end
				OP_INY, OP_DEY: begin
					a_src_o = A_SRC_Y;
					b_src_o = B_SRC_ONE;
					dst_o = DST_Y;
				end
				default: ;
			endcase

			// Function; loads keep the TXB default
			case (opcode_i)
				OP_ADC, OP_INX, OP_INY: alu_func_o = ALU_ADD;
				OP_SBC, OP_DEX, OP_DEY: alu_func_o = ALU_SUB;
				OP_AND: alu_func_o = ALU_AND;
				OP_ORA: alu_func_o = ALU_ORA;
				OP_EOR: alu_func_o = ALU_EOR;
				OP_ASL: alu_func_o = ALU_ASL;
				OP_LSR: alu_func_o = ALU_LSR;
				OP_ROL: alu_func_o = ALU_ROL;
				OP_ROR: alu_func_o = ALU_ROR;
				OP_STA, OP_STX, OP_STY: begin
					alu_func_o = ALU_TXA;
					dst_o = DST_BUS;
					bus_we_o = 1'b1;
				end
				default: ;
			endcase

			if (!(opcode_i inside {OP_STA, OP_STX, OP_STY, OP_JMP, OP_NOP})) begin
				p_mask_o[`STATUS_N] = 1'b1;
				p_mask_o[`STATUS_Z] = 1'b1;
			end
			if (opcode_i inside {OP_ADC, OP_SBC, OP_ASL, OP_LSR, OP_ROL, OP_ROR})
				p_mask_o[`STATUS_C] = 1'b1;
			if (opcode_i inside {OP_ADC, OP_SBC})
				p_mask_o[`STATUS_V] = 1'b1;
		end

		// No register is written while reset is held
		if (!rst_n_i) begin
			pc_inc_o = 1'b0;
			dst_o    = DST_NONE;
		end
	end

	// Stores only go out through the address latch
	a_we_off_pc: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		!(bus_we_o && pc_addr_oe_o))
		else $error("bus write while PC drives the address");

	a_pc_one_op: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
		!(pc_load_o && pc_inc_o))
		else $error("PC load and increment in the same cycle");

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_decoder (
	input  logic [`DATA_W-1:0]  ir_i,
	output cpu_pkg::opcode_e    opcode_o,
	output cpu_pkg::addr_mode_e mode_o
);

	import cpu_pkg::*;

	always_comb begin
		case (ir_i)
			8'h69, 8'h6d: opcode_o = OP_ADC;
			8'he9, 8'hed: opcode_o = OP_SBC;
			8'h29, 8'h2d: opcode_o = OP_AND;
			8'h09, 8'h0d: opcode_o = OP_ORA;
			8'h49, 8'h4d: opcode_o = OP_EOR;
			8'ha9, 8'had: opcode_o = OP_LDA;
			8'ha2, 8'hae: opcode_o = OP_LDX;
			8'ha0, 8'hac: opcode_o = OP_LDY;
			8'h8d:        opcode_o = OP_STA;
			8'h8e:        opcode_o = OP_STX;
			8'h8c:        opcode_o = OP_STY;
			8'h0a:        opcode_o = OP_ASL;
			8'h4a:        opcode_o = OP_LSR;
			8'h2a:        opcode_o = OP_ROL;
			8'h6a:        opcode_o = OP_ROR;
			8'he8:        opcode_o = OP_INX;
			8'hc8:        opcode_o = OP_INY;
			8'hca:        opcode_o = OP_DEX;
			8'h88:        opcode_o = OP_DEY;
			8'h4c:        opcode_o = OP_JMP;
			default:      opcode_o = OP_NOP;
		endcase
	end

	// All supported absolute encodings have bits 3:2 set
	always_comb begin
		if (opcode_o == OP_NOP)
			mode_o = MODE_IMP;
		else if (ir_i[3:2] == 2'b11)
			mode_o = MODE_ABS;
		else if (opcode_o inside {OP_ASL, OP_LSR, OP_ROL, OP_ROR,
				OP_INX, OP_INY, OP_DEX, OP_DEY})
			mode_o = MODE_IMP;
		else
			mode_o = MODE_IMM;
	end

endmodule

/* hdl/cpu_pkg.sv */
`include "cpu_params.svh"

package cpu_pkg;

	// Decoded operation
	typedef enum logic [4:0] {
		OP_ADC, OP_SBC, OP_AND, OP_ORA, OP_EOR,
		OP_LDA, OP_LDX, OP_LDY,
		OP_STA, OP_STX, OP_STY,
		OP_ASL, OP_LSR, OP_ROL, OP_ROR,
		OP_INX, OP_INY, OP_DEX, OP_DEY,
		OP_JMP, OP_NOP
	} opcode_e;

	typedef enum logic [1:0] {
		MODE_IMP,
		MODE_IMM,
		MODE_ABS
	} addr_mode_e;

	// TXA and TXB pass one operand straight through
	typedef enum logic [3:0] {
		ALU_TXA, ALU_TXB,
		ALU_ADD, ALU_SUB,
		ALU_AND, ALU_ORA, ALU_EOR,
		ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR
	} alu_func_e;

	typedef enum logic [1:0] {
		A_SRC_BUS,
		A_SRC_ACC,
		A_SRC_X,
		A_SRC_Y
	} a_src_e;

	typedef enum logic {
		B_SRC_BUS,
		B_SRC_ONE
	} b_src_e;

	typedef enum logic [2:0] {
		DST_NONE,
		DST_ACC,
		DST_X,
		DST_Y,
		DST_ADL,
		DST_ADH,
		DST_BUS
	} dst_e;

	// Field order follows the STATUS_* bit positions
	typedef union packed {
		logic [`DATA_W-1:0] raw;
		struct packed {
			logic n;
			logic v;
			logic [`STATUS_RSVD_W-1:0] rsvd;
			logic z;
			logic c;
		} flags;
	} status_u;

endpackage

/* include/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus widths
`define DATA_W 8
`define ADDR_W 16

// Low byte of the reset vector, high byte at the next address
`define RESET_VECTOR 16'hfffc

// Status byte bit positions
`define STATUS_N 7
`define STATUS_V 6
`define STATUS_Z 1
`define STATUS_C 0

// Reserved bits between V and Z
`define STATUS_RSVD_W 4

`endif
